// ==== Bender.yml ====
package:
  name: cv_controller

sources:
  - files:
      - cv_input_pkg.sv
      - cv_ctrl_pkg.sv
      - cv_keyboard_keypad.sv
      - cv_controller_port.sv
      - cv_controller_top.sv
  - target: test
    files:
      - tb_cv_controller_assertions.sv
      - tb_cv_controller.sv

// ==== cv_controller_port.sv ====
// one console hand controller port
// merges the chosen host joystick with the keyboard keypad and drives
// the control lines as selected by the keypad and joystick strobes

`timescale 1ns/1ps

module cv_controller_port
	import cv_input_pkg::*;
	import cv_ctrl_pkg::*;
#(
	parameter int PORT_INDEX = 0
)(
	input  host_joy_t  joy0_i,
	input  host_joy_t  joy1_i,
	input  logic       swap_i,
	input  keypad_t    kbd_keypad_i,
	input  logic       keypad_sel_n_i,
	input  logic       joy_sel_n_i,
	output ctrl_port_t port_o
);

	host_joy_t    joy;
	keypad_t      keypad;
	ctrl_nibble_t key_code;
	ctrl_port_t   keypad_half;
	ctrl_port_t   joy_half;

	// host joystick bits rearranged into keypad positions
	function automatic keypad_t joy_to_keypad(host_joy_t j);
		keypad_t kp;
		kp = '0;
		for (int d = 0; d < 10; d++) begin
			kp[KP_DIGIT0 + d] = j[JOY_DIGIT0 + d];
		end
		kp[KP_STAR]   = j[JOY_STAR];
		kp[KP_NUMBER] = j[JOY_NUMBER];
		kp[KP_PURPLE] = j[JOY_PURPLE];
		kp[KP_BLUE]   = j[JOY_BLUE];
		kp[KP_UP]     = j[JOY_UP];
		kp[KP_DOWN]   = j[JOY_DOWN];
		kp[KP_LEFT]   = j[JOY_LEFT];
		kp[KP_RIGHT]  = j[JOY_RIGHT];
		kp[KP_FIRE1]  = j[JOY_FIRE1];
		kp[KP_FIRE2]  = j[JOY_FIRE2];
		return kp;
	endfunction

	// ========================================
	// joystick select and merge
	// ========================================

	// port 0 normally follows joy0, the others joy1, swap exchanges them
	assign joy = ((PORT_INDEX == 0) ^ swap_i) ? joy0_i : joy1_i;

	assign keypad = joy_to_keypad(joy) | kbd_keypad_i;

	// ========================================
	// keypad priority encoder
	// ========================================

	// lowest position wins, triggers count as keys
	always_comb begin
		casez (keypad[KP_DIGIT0:KP_BLUE])
			14'b1?????????????: key_code = KEY_0;
			14'b01????????????: key_code = KEY_1;
			14'b001???????????: key_code = KEY_2;
			14'b0001??????????: key_code = KEY_3;
			14'b00001?????????: key_code = KEY_4;
			14'b000001????????: key_code = KEY_5;
			14'b0000001???????: key_code = KEY_6;
			14'b00000001??????: key_code = KEY_7;
			14'b000000001?????: key_code = KEY_8;
			14'b0000000001????: key_code = KEY_9;
			14'b00000000001???: key_code = KEY_STAR;
			14'b000000000001??: key_code = KEY_NUMBER;
			14'b0000000000001?: key_code = KEY_PURPLE;
			14'b00000000000001: key_code = KEY_BLUE;
			default:            key_code = KEY_NONE;
		endcase
	end

	// ========================================
	// strobe halves
	// ========================================

	// keypad strobe low, key code plus fire 2
	always_comb begin
		keypad_half = CTRL_IDLE;
		if (!keypad_sel_n_i) begin
			keypad_half.lines  = key_code;
			keypad_half.fire_n = ~keypad[KP_FIRE2];
		end
	end

	// joystick strobe low, up/down/left/right on lines 3..0 plus fire 1
	always_comb begin
		joy_half = CTRL_IDLE;
		if (!joy_sel_n_i) begin
			joy_half.lines  = ~keypad[KP_UP:KP_RIGHT];
			joy_half.fire_n = ~keypad[KP_FIRE1];
		end
	end

	// open collector style wired AND of both halves, lines and fire alike
	assign port_o = keypad_half & joy_half;

endmodule

// ==== cv_controller_top.f ====
cv_input_pkg.sv
cv_ctrl_pkg.sv
cv_keyboard_keypad.sv
cv_controller_port.sv
cv_controller_top.sv
tb_cv_controller_assertions.sv
tb_cv_controller.sv

// ==== cv_controller_top.sv ====
// hand controller input path of the console
// one shared keyboard keypad decoder feeding NUM_PORTS controller ports,
// each port is read through its own keypad and joystick strobes

`timescale 1ns/1ps

module cv_controller_top
	import cv_input_pkg::*;
	import cv_ctrl_pkg::*;
#(
	parameter int NUM_PORTS = 2
)(
	input  logic                       clk_sys,
	input  logic                       arst_n_i,
	input  host_joy_t                  joy0_i,
	input  host_joy_t                  joy1_i,
	input  logic                       swap_i,
	input  ps2_key_t                   ps2_key_i,
	// console port 5 strobes
	input  logic [NUM_PORTS-1:0]       keypad_sel_n_i,
	// console port 8 strobes
	input  logic [NUM_PORTS-1:0]       joy_sel_n_i,
	output ctrl_port_t [NUM_PORTS-1:0] ctrl_port_o
);

	keypad_t kbd_keypad;

	// ========================================
	// keyboard emulation
	// ========================================

	cv_keyboard_keypad u_keyboard (
		.clk_sys      (clk_sys),
		.arst_n_i     (arst_n_i),
		.ps2_key_i    (ps2_key_i),
		.kbd_keypad_o (kbd_keypad)
	);

	// ========================================
	// controller ports
	// ========================================

	// keyboard keypad is seen by every player
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		cv_controller_port #(
			.PORT_INDEX (p)
		) u_port (
			.joy0_i         (joy0_i),
			.joy1_i         (joy1_i),
			.swap_i         (swap_i),
			.kbd_keypad_i   (kbd_keypad),
			.keypad_sel_n_i (keypad_sel_n_i[p]),
			.joy_sel_n_i    (joy_sel_n_i[p]),
			.port_o         (ctrl_port_o[p])
		);
	end

endmodule

// ==== cv_ctrl_pkg.sv ====
// console side definitions for the hand controller ports
// keypad word positions, the 4-bit key codes read on the control
// lines and the per-port line bundle

package cv_ctrl_pkg;

	// ========================================
	// keypad word
	// ========================================

	// 20 buttons, set bit means pressed, index 0 is the MSB
	typedef logic [0:19] keypad_t;

	// digits 0 to 9 sit at positions 0 to 9
	localparam int KP_DIGIT0 = 0;
	localparam int KP_STAR   = 10;
	localparam int KP_NUMBER = 11;
	localparam int KP_PURPLE = 12;
	localparam int KP_BLUE   = 13;
	localparam int KP_UP     = 14;
	localparam int KP_DOWN   = 15;
	localparam int KP_LEFT   = 16;
	localparam int KP_RIGHT  = 17;
	localparam int KP_FIRE1  = 18;
	localparam int KP_FIRE2  = 19;

	// ========================================
	// controller port lines
	// ========================================

	// active low control lines
	typedef logic [3:0] ctrl_nibble_t;

	typedef struct packed {
		ctrl_nibble_t lines;
		logic         fire_n;
	} ctrl_port_t;

	// codes driven on the lines in keypad mode
	localparam ctrl_nibble_t KEY_0      = 4'b0011;
	localparam ctrl_nibble_t KEY_1      = 4'b1110;
	localparam ctrl_nibble_t KEY_2      = 4'b1101;
	localparam ctrl_nibble_t KEY_3      = 4'b0110;
	localparam ctrl_nibble_t KEY_4      = 4'b0001;
	localparam ctrl_nibble_t KEY_5      = 4'b1001;
	localparam ctrl_nibble_t KEY_6      = 4'b0111;
	localparam ctrl_nibble_t KEY_7      = 4'b1100;
	localparam ctrl_nibble_t KEY_8      = 4'b1000;
	localparam ctrl_nibble_t KEY_9      = 4'b1011;
	localparam ctrl_nibble_t KEY_STAR   = 4'b1010;
	localparam ctrl_nibble_t KEY_NUMBER = 4'b0101;
	localparam ctrl_nibble_t KEY_PURPLE = 4'b0100;
	localparam ctrl_nibble_t KEY_BLUE   = 4'b0010;
	localparam ctrl_nibble_t KEY_NONE   = 4'b1111;

	// what an unselected half puts on the port
	localparam ctrl_port_t CTRL_IDLE = '{lines: KEY_NONE, fire_n: 1'b1};

endpackage

// ==== cv_input_pkg.sv ====
// host side definitions for the controller input path
// joystick word layout from the host link and the PS/2 scan codes
// that the keypad emulation reacts to

package cv_input_pkg;

	// ========================================
	// host joystick word
	// ========================================

	// set bit means pressed, bits 20 and up unused
	typedef logic [31:0] host_joy_t;

	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE1  = 4;
	localparam int JOY_FIRE2  = 5;
	localparam int JOY_STAR   = 6;
	localparam int JOY_NUMBER = 7;
	// digits 0 to 9 occupy bits 8 to 17
	localparam int JOY_DIGIT0 = 8;
	localparam int JOY_PURPLE = 18;
	localparam int JOY_BLUE   = 19;

	// ========================================
	// PS/2 key events
	// ========================================

	typedef logic [7:0] scan_code_t;

	// toggle flips once per make or break event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		scan_code_t code;
	} ps2_key_t;

	// main row digits
	localparam scan_code_t SC_MAIN_0 = 8'h45;
	localparam scan_code_t SC_MAIN_1 = 8'h16;
	localparam scan_code_t SC_MAIN_2 = 8'h1E;
	localparam scan_code_t SC_MAIN_3 = 8'h26;
	localparam scan_code_t SC_MAIN_4 = 8'h25;
	localparam scan_code_t SC_MAIN_5 = 8'h2E;
	localparam scan_code_t SC_MAIN_6 = 8'h36;
	localparam scan_code_t SC_MAIN_7 = 8'h3D;
	localparam scan_code_t SC_MAIN_8 = 8'h3E;
	localparam scan_code_t SC_MAIN_9 = 8'h46;

	// numeric keypad
	localparam scan_code_t SC_PAD_0     = 8'h70;
	localparam scan_code_t SC_PAD_1     = 8'h69;
	localparam scan_code_t SC_PAD_2     = 8'h72;
	localparam scan_code_t SC_PAD_3     = 8'h7A;
	localparam scan_code_t SC_PAD_4     = 8'h6B;
	localparam scan_code_t SC_PAD_5     = 8'h73;
	localparam scan_code_t SC_PAD_6     = 8'h74;
	localparam scan_code_t SC_PAD_7     = 8'h6C;
	localparam scan_code_t SC_PAD_8     = 8'h75;
	localparam scan_code_t SC_PAD_9     = 8'h7D;
	localparam scan_code_t SC_PAD_STAR  = 8'h7C;
	localparam scan_code_t SC_PAD_MINUS = 8'h7B;

	localparam scan_code_t SC_LSHIFT = 8'h12;
	localparam scan_code_t SC_RSHIFT = 8'h59;

endpackage

// ==== cv_keyboard_keypad.sv ====
// PS/2 keyboard to keypad emulation
// watches the toggle bit of the key event and keeps one held flag per
// emulated button, the resulting keypad word goes to every port

`timescale 1ns/1ps

module cv_keyboard_keypad
	import cv_input_pkg::*;
	import cv_ctrl_pkg::*;
(
	input  logic     clk_sys,
	input  logic     arst_n_i,
	input  ps2_key_t ps2_key_i,
	output keypad_t  kbd_keypad_o
);

	logic       toggle_q;
	logic [9:0] digit_q;
	logic       star_q;
	logic       shift_q;
	logic       minus_q;

	logic       key_event;
	logic [9:0] digit_hit;
	logic       star_hit;
	logic       shift_hit;
	logic       minus_hit;

	// ========================================
	// scan code decode
	// ========================================

	// new event whenever toggle differs from the last sample
	assign key_event = ps2_key_i.toggle != toggle_q;

	// extended prefix is ignored, only the code byte matters
	always_comb begin
		digit_hit = '0;
		star_hit  = 1'b0;
		shift_hit = 1'b0;
		minus_hit = 1'b0;
		case (ps2_key_i.code)
			SC_MAIN_0, SC_PAD_0: digit_hit[0] = 1'b1;
			SC_MAIN_1, SC_PAD_1: digit_hit[1] = 1'b1;
			SC_MAIN_2, SC_PAD_2: digit_hit[2] = 1'b1;
			SC_MAIN_3, SC_PAD_3: digit_hit[3] = 1'b1;
			SC_MAIN_4, SC_PAD_4: digit_hit[4] = 1'b1;
			SC_MAIN_5, SC_PAD_5: digit_hit[5] = 1'b1;
			SC_MAIN_6, SC_PAD_6: digit_hit[6] = 1'b1;
			SC_MAIN_7, SC_PAD_7: digit_hit[7] = 1'b1;
			SC_MAIN_8, SC_PAD_8: digit_hit[8] = 1'b1;
			SC_MAIN_9, SC_PAD_9: digit_hit[9] = 1'b1;
			SC_PAD_STAR:         star_hit     = 1'b1;
			SC_LSHIFT, SC_RSHIFT: shift_hit   = 1'b1;
			SC_PAD_MINUS:        minus_hit    = 1'b1;
			default: ;
		endcase
	end

	// ========================================
	// held button state
	// ========================================

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			toggle_q <= 1'b0;
			digit_q  <= '0;
			star_q   <= 1'b0;
			shift_q  <= 1'b0;
			minus_q  <= 1'b0;
		end else begin
			toggle_q <= ps2_key_i.toggle;
			if (key_event) begin
				// make sets, break clears, other buttons keep their state
				digit_q <= (digit_q & ~digit_hit) | ({10{ps2_key_i.pressed}} & digit_hit);
				if (star_hit) begin
					star_q <= ps2_key_i.pressed;
				end
				if (shift_hit) begin
					shift_q <= ps2_key_i.pressed;
				end
				if (minus_hit) begin
					minus_q <= ps2_key_i.pressed;
				end
			end
		end
	end

	// ========================================
	// keypad word
	// ========================================

	always_comb begin
		kbd_keypad_o = '0;
		for (int d = 0; d < 10; d++) begin
			kbd_keypad_o[KP_DIGIT0 + d] = digit_q[d];
		end
		// shift+8 is '*' and shift+3 is '#' on a PC keyboard
		kbd_keypad_o[KP_STAR]   = star_q | (shift_q & digit_q[8]);
		kbd_keypad_o[KP_NUMBER] = minus_q | (shift_q & digit_q[3]);
	end

endmodule

// ==== tb_cv_controller.sv ====
// testbench for the hand controller input path
// drives joysticks, strobes and PS/2 key events into the top level and
// compares every port with a reference model on each falling clock edge

`timescale 1ns/1ps

module tb_cv_controller
	import cv_input_pkg::*;
	import cv_ctrl_pkg::*;
();

	localparam int  NUM_PORTS      = 2;
	localparam time CLK_PERIOD     = 40ns;
	localparam int  PLANNED_CYCLES = 450;
	localparam time WATCHDOG_TIME  = CLK_PERIOD * PLANNED_CYCLES * 10;

	logic                       clk_sys = 1'b0;
	logic                       arst_n;
	host_joy_t                  joy0;
	host_joy_t                  joy1;
	logic                       swap;
	ps2_key_t                   ps2_key;
	logic [NUM_PORTS-1:0]       keypad_sel_n;
	logic [NUM_PORTS-1:0]       joy_sel_n;
	ctrl_port_t [NUM_PORTS-1:0] ctrl_port;

	// keyboard buttons as the model expects them after the last edge
	logic [9:0] kb_digit  = '0;
	logic       kb_star   = 1'b0;
	logic       kb_shift  = 1'b0;
	logic       kb_minus  = 1'b0;
	logic       kb_toggle = 1'b0;
	string      test_name = "reset_idle";

	cv_controller_top #(
		.NUM_PORTS (NUM_PORTS)
	) dut0 (
		.clk_sys        (clk_sys),
		.arst_n_i       (arst_n),
		.joy0_i         (joy0),
		.joy1_i         (joy1),
		.swap_i         (swap),
		.ps2_key_i      (ps2_key),
		.keypad_sel_n_i (keypad_sel_n),
		.joy_sel_n_i    (joy_sel_n),
		.ctrl_port_o    (ctrl_port)
	);

	bind cv_controller_top tb_cv_controller_assertions #(
		.NUM_PORTS (NUM_PORTS)
	) u_assertions (
		.clk_sys        (clk_sys),
		.arst_n_i       (arst_n_i),
		.keypad_sel_n_i (keypad_sel_n_i),
		.joy_sel_n_i    (joy_sel_n_i),
		.ctrl_port_o    (ctrl_port_o)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	// ========================================
	// reference model
	// ========================================

	function automatic logic [3:0] key_code_of(int pos);
		case (pos)
			0:       return 4'b0011;
			1:       return 4'b1110;
			2:       return 4'b1101;
			3:       return 4'b0110;
			4:       return 4'b0001;
			5:       return 4'b1001;
			6:       return 4'b0111;
			7:       return 4'b1100;
			8:       return 4'b1000;
			9:       return 4'b1011;
			10:      return 4'b1010;
			11:      return 4'b0101;
			12:      return 4'b0100;
			13:      return 4'b0010;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic scan_code_t main_code(int d);
		case (d)
			0:       return 8'h45;
			1:       return 8'h16;
			2:       return 8'h1E;
			3:       return 8'h26;
			4:       return 8'h25;
			5:       return 8'h2E;
			6:       return 8'h36;
			7:       return 8'h3D;
			8:       return 8'h3E;
			9:       return 8'h46;
			default: return 8'h00;
		endcase
	endfunction

	function automatic scan_code_t pad_code(int d);
		case (d)
			0:       return 8'h70;
			1:       return 8'h69;
			2:       return 8'h72;
			3:       return 8'h7A;
			4:       return 8'h6B;
			5:       return 8'h73;
			6:       return 8'h74;
			7:       return 8'h6C;
			8:       return 8'h75;
			9:       return 8'h7D;
			default: return 8'h00;
		endcase
	endfunction

	// bit i of the result is keypad position i
	function automatic logic [19:0] port_keypad(int p);
		host_joy_t   j;
		logic [19:0] kp;
		j = ((p == 0) != swap) ? joy0 : joy1;
		for (int d = 0; d < 10; d++) begin
			kp[d] = j[8 + d] | kb_digit[d];
		end
		kp[10] = j[6] | kb_star | (kb_shift & kb_digit[8]);
		kp[11] = j[7] | kb_minus | (kb_shift & kb_digit[3]);
		kp[12] = j[18];
		kp[13] = j[19];
		kp[14] = j[3];
		kp[15] = j[2];
		kp[16] = j[1];
		kp[17] = j[0];
		kp[18] = j[4];
		kp[19] = j[5];
		return kp;
	endfunction

	function automatic logic [4:0] expected_port(int p);
		logic [19:0] kp;
		logic [3:0]  kp_lines;
		logic        kp_fire;
		logic [3:0]  js_lines;
		logic        js_fire;
		kp       = port_keypad(p);
		kp_lines = 4'b1111;
		kp_fire  = 1'b1;
		js_lines = 4'b1111;
		js_fire  = 1'b1;
		if (!keypad_sel_n[p]) begin
			// scan from the top so the lowest position ends up winning
			for (int i = 13; i >= 0; i--) begin
				if (kp[i]) begin
					kp_lines = key_code_of(i);
				end
			end
			kp_fire = ~kp[19];
		end
		if (!joy_sel_n[p]) begin
			js_lines = ~{kp[14], kp[15], kp[16], kp[17]};
			js_fire  = ~kp[18];
		end
		return {kp_lines & js_lines, kp_fire & js_fire};
	endfunction

	task automatic apply_key_event(ps2_key_t k);
		for (int d = 0; d < 10; d++) begin
			if (k.code == main_code(d) || k.code == pad_code(d)) begin
				kb_digit[d] = k.pressed;
			end
		end
		case (k.code)
			8'h7C:        kb_star  = k.pressed;
			8'h7B:        kb_minus = k.pressed;
			8'h12, 8'h59: kb_shift = k.pressed;
			default: ;
		endcase
	endtask

	// key event driven at one edge is taken at the next
	always @(posedge clk_sys) begin
		if (!arst_n) begin
			kb_digit  = '0;
			kb_star   = 1'b0;
			kb_shift  = 1'b0;
			kb_minus  = 1'b0;
			kb_toggle = 1'b0;
		end else begin
			if (ps2_key.toggle != kb_toggle) begin
				apply_key_event(ps2_key);
			end
			kb_toggle = ps2_key.toggle;
		end
	end

	// ========================================
	// checking and watchdog
	// ========================================

	always @(negedge clk_sys) begin
		if (dut0.u_assertions.fail_count != 0) begin
			stop_with_failure("a concurrent assertion on the top level failed");
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			assert (ctrl_port[p] === expected_port(p))
			else stop_with_failure($sformatf("error %s: port %0d expected %b actual %b",
				test_name, p, expected_port(p), ctrl_port[p]));
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		stop_with_failure($sformatf("run did not finish within %0t", WATCHDOG_TIME));
	end

	// ========================================
	// stimulus
	// ========================================

	function automatic logic [NUM_PORTS-1:0] random_strobe();
		return NUM_PORTS'($urandom);
	endfunction

	// few bits set, so the encoder sees varied winners
	function automatic host_joy_t sparse_joy();
		return host_joy_t'($urandom & $urandom & $urandom) & 32'h000F_FFFF;
	endfunction

	task automatic drive_cycle(host_joy_t j0, host_joy_t j1, logic sw,
		logic [NUM_PORTS-1:0] ksel, logic [NUM_PORTS-1:0] jsel);
		@(posedge clk_sys);
		joy0         <= j0;
		joy1         <= j1;
		swap         <= sw;
		keypad_sel_n <= ksel;
		joy_sel_n    <= jsel;
	endtask

	task automatic send_key(scan_code_t code, logic pressed, logic ext);
		@(posedge clk_sys);
		ps2_key <= '{toggle: ~ps2_key.toggle, pressed: pressed, extended: ext, code: code};
		repeat (3) begin
			drive_cycle(joy0, joy1, swap, random_strobe(), random_strobe());
		end
	endtask

	initial begin
		void'($urandom(51));
		joy0         = '0;
		joy1         = '0;
		swap         = 1'b0;
		ps2_key      = '0;
		keypad_sel_n = '1;
		joy_sel_n    = '1;
		arst_n       = 1'b0;

		repeat (2) begin
			@(posedge clk_sys);
			keypad_sel_n <= random_strobe();
			joy_sel_n    <= random_strobe();
		end
		arst_n <= 1'b1;
		repeat (10) drive_cycle('0, '0, 1'b0, random_strobe(), random_strobe());

		test_name = "keypad_walk";
		for (int b = 0; b < 20; b++) begin
			drive_cycle(32'(1) << b, 32'(1) << (19 - b), 1'b0, '0, '1);
		end
		test_name = "direction_walk";
		for (int b = 0; b < 20; b++) begin
			drive_cycle(32'(1) << b, 32'(1) << (19 - b), 1'b0, '1, '0);
		end
		test_name = "mixed_walk";
		for (int b = 0; b < 20; b++) begin
			drive_cycle(32'(1) << b, 32'(1) << (19 - b), 1'b0, '0, '0);
		end
		test_name = "random_words";
		repeat (130) begin
			drive_cycle(sparse_joy(), sparse_joy(), 1'($urandom), random_strobe(), random_strobe());
		end
		test_name = "swap";
		for (int i = 0; i < 20; i++) begin
			drive_cycle(sparse_joy(), sparse_joy(), i[0], '0, '0);
		end

		test_name = "keyboard_digits";
		drive_cycle('0, '0, 1'b0, '0, '1);
		for (int d = 0; d < 10; d++) begin
			send_key(main_code(d), 1'b1, 1'b0);
			send_key(main_code(d), 1'b0, 1'b0);
			// keypad keys arrive with the extended flag set here
			send_key(pad_code(d), 1'b1, 1'b1);
			send_key(pad_code(d), 1'b0, 1'b1);
		end
		test_name = "keyboard_shift";
		send_key(8'h12, 1'b1, 1'b0);
		send_key(main_code(8), 1'b1, 1'b0);
		send_key(main_code(8), 1'b0, 1'b0);
		send_key(main_code(3), 1'b1, 1'b0);
		send_key(8'h12, 1'b0, 1'b0);
		send_key(8'h59, 1'b1, 1'b0);
		send_key(main_code(3), 1'b0, 1'b0);
		send_key(8'h59, 1'b0, 1'b0);
		test_name = "keyboard_minus_star";
		send_key(8'h7B, 1'b1, 1'b0);
		send_key(8'h7B, 1'b0, 1'b0);
		send_key(8'h7C, 1'b1, 1'b0);
		send_key(8'h7C, 1'b0, 1'b0);
		test_name = "keyboard_unmapped";
		send_key(8'h1C, 1'b1, 1'b0);
		send_key(8'h1C, 1'b0, 1'b0);
		test_name = "keyboard_joystick_mix";
		drive_cycle(32'(1) << 10, 32'(1) << 15, 1'b0, '0, '1);
		send_key(pad_code(5), 1'b1, 1'b0);
		send_key(pad_code(5), 1'b0, 1'b0);

		test_name = "drain";
		repeat (3) drive_cycle('0, '0, 1'b0, '1, '1);
		// one more cycle so the last driven values are checked first
		repeat (2) @(negedge clk_sys);
		if (dut0.u_assertions.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_with_failure("a concurrent assertion on the top level failed");
		end
	end

endmodule

// ==== tb_cv_controller_assertions.sv ====
// concurrent checks on the controller top level, bound into it
// from the testbench; fail_count is read back by the testbench

`timescale 1ns/1ps

module tb_cv_controller_assertions
	import cv_ctrl_pkg::*;
#(
	parameter int NUM_PORTS = 2
)(
	input logic                       clk_sys,
	input logic                       arst_n_i,
	input logic [NUM_PORTS-1:0]       keypad_sel_n_i,
	input logic [NUM_PORTS-1:0]       joy_sel_n_i,
	input ctrl_port_t [NUM_PORTS-1:0] ctrl_port_o
);

	localparam ctrl_port_t IDLE_PORT = '{lines: 4'b1111, fire_n: 1'b1};

	int fail_count = 0;

	// ========================================
	// per port checks
	// ========================================

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		// idle lines while reset is held
		a_idle_in_reset: assert property (
			@(posedge clk_sys) !arst_n_i |-> ctrl_port_o[p] == IDLE_PORT
		) else begin
			$error("port %0d not idle during reset", p);
			fail_count++;
		end

		// nothing strobed, nothing driven
		a_idle_unselected: assert property (
			@(posedge clk_sys) keypad_sel_n_i[p] && joy_sel_n_i[p]
				|-> ctrl_port_o[p] == IDLE_PORT
		) else begin
			$error("port %0d driven with both strobes high", p);
			fail_count++;
		end
	end

	// ========================================
	// whole output
	// ========================================

	a_known_outputs: assert property (
		@(posedge clk_sys) disable iff (!arst_n_i) !$isunknown(ctrl_port_o)
	) else begin
		$error("controller port output unknown after reset");
		fail_count++;
	end

endmodule
